// File: design/mem_defs.svh
`ifndef MEM_DEFS_SVH
`define MEM_DEFS_SVH

`define MEM_ADDR_W      32
`define MEM_DATA_W      32
`define MEM_PAGE_OFS_W  12
`define MEM_TLB_ENTRIES 4
`define MEM_RAM_WORDS   256

// Derived widths
`define MEM_VPN_W     (`MEM_ADDR_W - `MEM_PAGE_OFS_W)
`define MEM_TLB_IDX_W ($clog2(`MEM_TLB_ENTRIES))
`define MEM_RAM_IDX_W ($clog2(`MEM_RAM_WORDS))

`endif

// File: design/mem_pkg.sv
package mem_pkg;

    // Memory opcodes from the execute stage
    typedef enum logic [3:0] {
        MEM_NOP,
        MEM_LD_B,
        MEM_LD_BU,
        MEM_LD_H,
        MEM_LD_HU,
        MEM_LD_W,
        MEM_ST_B,
        MEM_ST_H,
        MEM_ST_W,
        MEM_LL,
        MEM_SC
    } mem_op_e;

    // Memory exception codes
    typedef enum logic [2:0] {
        EXCP_NONE,
        EXCP_ADEM,
        EXCP_TLBR,
        EXCP_PIL,
        EXCP_PIS,
        EXCP_PPI,
        EXCP_PME
    } excp_e;

endpackage

// File: design/dtlb.sv
`timescale 1ns/1ps
`include "mem_defs.svh"

module dtlb (
    input  logic                                clk,
    input  logic                                rst,
    input  logic [`MEM_VPN_W-1:0]               lookup_vpn_i,
    input  logic                                fill_we_i,
    input  logic [`MEM_VPN_W-1:0]               fill_vpn_i,
    input  logic [`MEM_VPN_W-1:0]               fill_ppn_i,
    input  logic                                fill_v_i,
    input  logic                                fill_d_i,
    input  logic [1:0]                          fill_plv_i,
    output logic                                hit_o,
    output logic [`MEM_VPN_W-1:0]               ppn_o,
    output logic                                v_o,
    output logic                                d_o,
    output logic [1:0]                          plv_o
);

    logic [`MEM_TLB_ENTRIES-1:0]                present_q;
    logic [`MEM_VPN_W-`MEM_TLB_IDX_W-1:0]       tag_q [`MEM_TLB_ENTRIES];
    logic [`MEM_VPN_W-1:0]                      ppn_q [`MEM_TLB_ENTRIES];
    logic [`MEM_TLB_ENTRIES-1:0]                v_q;
    logic [`MEM_TLB_ENTRIES-1:0]                d_q;
    logic [1:0]                                 plv_q [`MEM_TLB_ENTRIES];
    logic [`MEM_TLB_IDX_W-1:0]                  fill_idx;
    logic [`MEM_TLB_IDX_W-1:0]                  look_idx;

    assign fill_idx = fill_vpn_i[`MEM_TLB_IDX_W-1:0];
    assign look_idx = lookup_vpn_i[`MEM_TLB_IDX_W-1:0];

    always_ff @(posedge clk) begin
        if (rst) begin
            present_q <= '0;
        end else if (fill_we_i) begin
            present_q[fill_idx] <= 1'b1;
        end
    end

    // Entry contents, only meaningful once present
    always_ff @(posedge clk) begin
        if (fill_we_i) begin
            tag_q[fill_idx] <= fill_vpn_i[`MEM_VPN_W-1:`MEM_TLB_IDX_W];
            ppn_q[fill_idx] <= fill_ppn_i;
            v_q[fill_idx]   <= fill_v_i;
            d_q[fill_idx]   <= fill_d_i;
            plv_q[fill_idx] <= fill_plv_i;
        end
    end

    assign hit_o = present_q[look_idx] &&
                   (tag_q[look_idx] == lookup_vpn_i[`MEM_VPN_W-1:`MEM_TLB_IDX_W]);
    assign ppn_o = ppn_q[look_idx];
    assign v_o   = v_q[look_idx];
    assign d_o   = d_q[look_idx];
    assign plv_o = plv_q[look_idx];

endmodule

// File: design/mem1_stage.sv
`timescale 1ns/1ps
`include "mem_defs.svh"

module mem1_stage (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        advance_i,
    input  logic                        flush_i,
    input  logic                        valid_i,
    input  mem_pkg::mem_op_e            op_i,
    input  logic [`MEM_ADDR_W-1:0]      vaddr_i,
    input  logic [`MEM_DATA_W-1:0]      wdata_i,
    input  logic [4:0]                  rd_i,
    input  logic                        trans_en_i,
    input  logic [1:0]                  plv_i,
    output logic [`MEM_VPN_W-1:0]       tlb_vpn_o,
    input  logic                        tlb_hit_i,
    input  logic [`MEM_VPN_W-1:0]       tlb_ppn_i,
    input  logic                        tlb_v_i,
    input  logic                        tlb_d_i,
    input  logic [1:0]                  tlb_plv_i,
    input  logic                        llbit_i,
    output logic                        req_o,
    output logic                        req_we_o,
    output logic [3:0]                  req_be_o,
    output logic [`MEM_RAM_IDX_W-1:0]   req_idx_o,
    output logic [`MEM_DATA_W-1:0]      req_wdata_o,
    output logic                        m2_valid_o,
    output mem_pkg::mem_op_e            m2_op_o,
    output logic [4:0]                  m2_rd_o,
    output logic [1:0]                  m2_ofs_o,
    output mem_pkg::excp_e              m2_excp_o,
    output logic                        m2_sc_ok_o
);

    logic [`MEM_ADDR_W-1:0] paddr;
    logic [1:0]             ofs;
    logic                   is_load;
    logic                   is_store;
    logic                   sc_ok;
    logic                   do_req;
    mem_pkg::excp_e         excp;

    assign tlb_vpn_o = vaddr_i[`MEM_ADDR_W-1:`MEM_PAGE_OFS_W];
    assign paddr = trans_en_i ? {tlb_ppn_i, vaddr_i[`MEM_PAGE_OFS_W-1:0]} : vaddr_i;
    assign ofs = paddr[1:0];

    assign is_load = (op_i inside {mem_pkg::MEM_LD_B, mem_pkg::MEM_LD_BU, mem_pkg::MEM_LD_H,
                                   mem_pkg::MEM_LD_HU, mem_pkg::MEM_LD_W, mem_pkg::MEM_LL});
    assign is_store = (op_i inside {mem_pkg::MEM_ST_B, mem_pkg::MEM_ST_H, mem_pkg::MEM_ST_W,
                                    mem_pkg::MEM_SC});
    assign sc_ok = (op_i == mem_pkg::MEM_SC) && llbit_i;

    // Exception priority ADEM > TLBR > PIL/PIS > PPI > PME
    always_comb begin
        excp = mem_pkg::EXCP_NONE;
        if (valid_i && (is_load || is_store) && trans_en_i) begin
            if (plv_i == 2'd3 && vaddr_i[31]) begin
                excp = mem_pkg::EXCP_ADEM;
            end else if (!tlb_hit_i) begin
                excp = mem_pkg::EXCP_TLBR;
            end else if (!tlb_v_i) begin
                excp = is_store ? mem_pkg::EXCP_PIS : mem_pkg::EXCP_PIL;
            end else if (plv_i > tlb_plv_i) begin
                excp = mem_pkg::EXCP_PPI;
            end else if (is_store && !tlb_d_i) begin
                excp = mem_pkg::EXCP_PME;
            end
        end
    end

    // Failed SC never reaches the RAM
    assign do_req = advance_i && !flush_i && valid_i && (excp == mem_pkg::EXCP_NONE) &&
                    (is_load || (is_store && (op_i != mem_pkg::MEM_SC || sc_ok)));

    assign req_o = do_req;
    assign req_idx_o = paddr[`MEM_RAM_IDX_W+1:2];

    always_comb begin
        req_we_o = 1'b0;
        req_be_o = 4'b0000;
        req_wdata_o = '0;
        if (do_req) begin
            case (op_i)
                mem_pkg::MEM_LD_B, mem_pkg::MEM_LD_BU: req_be_o = 4'b0001 << ofs;
                mem_pkg::MEM_LD_H, mem_pkg::MEM_LD_HU: req_be_o = 4'b0011 << ofs;
                mem_pkg::MEM_LD_W, mem_pkg::MEM_LL:    req_be_o = 4'b1111;
                mem_pkg::MEM_ST_B: begin
                    req_we_o = 1'b1;
                    req_be_o = 4'b0001 << ofs;
                    req_wdata_o = {24'b0, wdata_i[7:0]} << (8 * ofs);
                end
                mem_pkg::MEM_ST_H: begin
                    req_we_o = 1'b1;
                    req_be_o = 4'b0011 << ofs;
                    req_wdata_o = {16'b0, wdata_i[15:0]} << (8 * ofs);
                end
                mem_pkg::MEM_ST_W, mem_pkg::MEM_SC: begin
                    req_we_o = 1'b1;
                    req_be_o = 4'b1111;
                    req_wdata_o = wdata_i;
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush_i) begin
            m2_valid_o <= 1'b0;
            m2_op_o <= mem_pkg::MEM_NOP;
            m2_excp_o <= mem_pkg::EXCP_NONE;
        end else if (advance_i) begin
            m2_valid_o <= valid_i;
            m2_op_o <= op_i;
            m2_excp_o <= excp;
        end
    end

    always_ff @(posedge clk) begin
        if (advance_i) begin
            m2_rd_o <= rd_i;
            m2_ofs_o <= ofs;
            m2_sc_ok_o <= sc_ok;
        end
    end

endmodule

// File: design/dcache_ram.sv
`timescale 1ns/1ps
`include "mem_defs.svh"

module dcache_ram (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        req_i,
    input  logic                        we_i,
    input  logic [3:0]                  be_i,
    input  logic [`MEM_RAM_IDX_W-1:0]   idx_i,
    input  logic [`MEM_DATA_W-1:0]      wdata_i,
    output logic [`MEM_DATA_W-1:0]      rdata_o,
    output logic                        ack_o
);

    logic [`MEM_DATA_W-1:0] mem_q [`MEM_RAM_WORDS];

    // Byte-lane writes
    always_ff @(posedge clk) begin
        if (req_i && we_i) begin
            for (int b = 0; b < 4; b++) begin
                if (be_i[b]) begin
                    mem_q[idx_i][8*b +: 8] <= wdata_i[8*b +: 8];
                end
            end
        end
    end

    // Whole word read, holds between requests
    always_ff @(posedge clk) begin
        if (req_i) begin
            rdata_o <= mem_q[idx_i];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ack_o <= 1'b0;
        end else begin
            ack_o <= req_i;
        end
    end

endmodule

// File: design/mem2_stage.sv
`timescale 1ns/1ps
`include "mem_defs.svh"

module mem2_stage (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    advance_i,
    input  logic                    flush_i,
    input  logic                    valid_i,
    input  mem_pkg::mem_op_e        op_i,
    input  logic [4:0]              rd_i,
    input  logic [1:0]              ofs_i,
    input  mem_pkg::excp_e          excp_i,
    input  logic                    sc_ok_i,
    input  logic [`MEM_DATA_W-1:0]  rdata_i,
    output logic                    llbit_o,
    output logic                    wb_valid_o,
    output logic                    wb_we_o,
    output logic [4:0]              wb_rd_o,
    output logic [`MEM_DATA_W-1:0]  wb_data_o,
    output mem_pkg::excp_e          excp_o
);

    logic [`MEM_DATA_W-1:0] shifted;
    logic                   ok;
    logic                   ll_upd;
    logic                   llbit_q;

    assign shifted = rdata_i >> (8 * ofs_i);
    assign ok = valid_i && (excp_i == mem_pkg::EXCP_NONE);

    always_comb begin
        case (op_i)
            mem_pkg::MEM_LD_B:  wb_data_o = {{24{shifted[7]}}, shifted[7:0]};
            mem_pkg::MEM_LD_BU: wb_data_o = {24'b0, shifted[7:0]};
            mem_pkg::MEM_LD_H:  wb_data_o = {{16{shifted[15]}}, shifted[15:0]};
            mem_pkg::MEM_LD_HU: wb_data_o = {16'b0, shifted[15:0]};
            mem_pkg::MEM_LD_W, mem_pkg::MEM_LL: wb_data_o = rdata_i;
            mem_pkg::MEM_SC:    wb_data_o = {31'b0, sc_ok_i};
            default:            wb_data_o = '0;
        endcase
    end

    assign wb_valid_o = valid_i;
    assign wb_rd_o = rd_i;
    assign excp_o = excp_i;
    // Loads, LL and SC write rd, plain stores do not
    assign wb_we_o = ok && (op_i inside {mem_pkg::MEM_LD_B, mem_pkg::MEM_LD_BU,
                                         mem_pkg::MEM_LD_H, mem_pkg::MEM_LD_HU,
                                         mem_pkg::MEM_LD_W, mem_pkg::MEM_LL, mem_pkg::MEM_SC});

    assign ll_upd = ok && (op_i == mem_pkg::MEM_LL || op_i == mem_pkg::MEM_SC);

    // A flush kills the op in mem2 too
    always_ff @(posedge clk) begin
        if (rst) begin
            llbit_q <= 1'b0;
        end else if (advance_i && !flush_i && ll_upd) begin
            llbit_q <= (op_i == mem_pkg::MEM_LL);
        end
    end

    // Pending update forwarded so an SC right behind an LL sees it
    assign llbit_o = ll_upd ? (op_i == mem_pkg::MEM_LL) : llbit_q;

endmodule

// File: design/mem_subsys_top.sv
`timescale 1ns/1ps
`include "mem_defs.svh"

module mem_subsys_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    valid_i,
    input  mem_pkg::mem_op_e        op_i,
    input  logic [`MEM_ADDR_W-1:0]  vaddr_i,
    input  logic [`MEM_DATA_W-1:0]  wdata_i,
    input  logic [4:0]              rd_i,
    input  logic                    trans_en_i,
    input  logic [1:0]              plv_i,
    input  logic                    advance_i,
    input  logic                    flush_i,
    input  logic                    tlb_we_i,
    input  logic [`MEM_VPN_W-1:0]   tlb_vpn_i,
    input  logic [`MEM_VPN_W-1:0]   tlb_ppn_i,
    input  logic                    tlb_v_i,
    input  logic                    tlb_d_i,
    input  logic [1:0]              tlb_plv_i,
    output logic                    wb_valid_o,
    output logic                    wb_we_o,
    output logic [4:0]              wb_rd_o,
    output logic [`MEM_DATA_W-1:0]  wb_data_o,
    output mem_pkg::excp_e          excp_o
);

    logic [`MEM_VPN_W-1:0]      lookup_vpn;
    logic                       tlb_hit;
    logic [`MEM_VPN_W-1:0]      tlb_ppn;
    logic                       tlb_v;
    logic                       tlb_d;
    logic [1:0]                 tlb_plv;
    logic                       llbit;
    logic                       ram_req;
    logic                       ram_we;
    logic [3:0]                 ram_be;
    logic [`MEM_RAM_IDX_W-1:0]  ram_idx;
    logic [`MEM_DATA_W-1:0]     ram_wdata;
    logic [`MEM_DATA_W-1:0]     ram_rdata;
    logic                       ram_ack;
    logic                       m2_valid;
    mem_pkg::mem_op_e           m2_op;
    logic [4:0]                 m2_rd;
    logic [1:0]                 m2_ofs;
    mem_pkg::excp_e             m2_excp;
    logic                       m2_sc_ok;

    dtlb u_dtlb (
        .clk(clk), .rst(rst), .lookup_vpn_i(lookup_vpn),
        .fill_we_i(tlb_we_i), .fill_vpn_i(tlb_vpn_i), .fill_ppn_i(tlb_ppn_i),
        .fill_v_i(tlb_v_i), .fill_d_i(tlb_d_i), .fill_plv_i(tlb_plv_i),
        .hit_o(tlb_hit), .ppn_o(tlb_ppn), .v_o(tlb_v), .d_o(tlb_d), .plv_o(tlb_plv)
    );

    mem1_stage u_mem1 (
        .clk(clk), .rst(rst), .advance_i(advance_i), .flush_i(flush_i),
        .valid_i(valid_i), .op_i(op_i), .vaddr_i(vaddr_i), .wdata_i(wdata_i), .rd_i(rd_i),
        .trans_en_i(trans_en_i), .plv_i(plv_i), .tlb_vpn_o(lookup_vpn),
        .tlb_hit_i(tlb_hit), .tlb_ppn_i(tlb_ppn), .tlb_v_i(tlb_v), .tlb_d_i(tlb_d),
        .tlb_plv_i(tlb_plv), .llbit_i(llbit),
        .req_o(ram_req), .req_we_o(ram_we), .req_be_o(ram_be), .req_idx_o(ram_idx),
        .req_wdata_o(ram_wdata), .m2_valid_o(m2_valid), .m2_op_o(m2_op), .m2_rd_o(m2_rd),
        .m2_ofs_o(m2_ofs), .m2_excp_o(m2_excp), .m2_sc_ok_o(m2_sc_ok)
    );

    dcache_ram u_ram (
        .clk(clk), .rst(rst), .req_i(ram_req), .we_i(ram_we), .be_i(ram_be),
        .idx_i(ram_idx), .wdata_i(ram_wdata), .rdata_o(ram_rdata), .ack_o(ram_ack)
    );

    mem2_stage u_mem2 (
        .clk(clk), .rst(rst), .advance_i(advance_i), .flush_i(flush_i),
        .valid_i(m2_valid), .op_i(m2_op), .rd_i(m2_rd), .ofs_i(m2_ofs), .excp_i(m2_excp),
        .sc_ok_i(m2_sc_ok), .rdata_i(ram_rdata), .llbit_o(llbit),
        .wb_valid_o(wb_valid_o), .wb_we_o(wb_we_o), .wb_rd_o(wb_rd_o),
        .wb_data_o(wb_data_o), .excp_o(excp_o)
    );

endmodule

// File: testbench/mem_subsys_chk.sv
`timescale 1ns/1ps
`include "mem_defs.svh"

module mem_subsys_chk (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    advance_i,
    input  logic                    flush_i,
    input  logic                    valid_i,
    input  logic                    ram_req,
    input  logic                    ram_ack,
    input  mem_pkg::excp_e          m2_excp,
    input  logic                    wb_valid_o,
    input  logic                    wb_we_o,
    input  logic [4:0]              wb_rd_o,
    input  logic [`MEM_DATA_W-1:0]  wb_data_o,
    input  mem_pkg::excp_e          excp_o
);

    // No writeback appears without an accepted op
    a_reset_quiet: assert property (@(posedge clk) rst |=> !wb_valid_o)
        else $error("wb_valid_o high right after reset");
    a_no_spurious_wb: assert property (@(posedge clk)
        (!rst && !wb_valid_o && !(advance_i && valid_i)) |=> !wb_valid_o)
        else $error("wb_valid_o rose without an accepted op");

    a_req_no_flush: assert property (@(posedge clk) ram_req |-> !flush_i)
        else $error("RAM request issued during flush");
    a_req_no_excp: assert property (@(posedge clk) disable iff (rst)
        ram_req |=> (m2_excp == mem_pkg::EXCP_NONE))
        else $error("RAM request issued for an op with an exception");

    a_ack_follows: assert property (@(posedge clk) disable iff (rst) ram_req |=> ram_ack)
        else $error("ack missing one cycle after request");
    a_ack_only: assert property (@(posedge clk) disable iff (rst) !ram_req |=> !ram_ack)
        else $error("ack without a request");

    a_stall_stable: assert property (@(posedge clk) disable iff (rst)
        (!advance_i && !flush_i) |=> ($stable(wb_valid_o) && $stable(wb_we_o) &&
        $stable(wb_rd_o) && $stable(wb_data_o) && $stable(excp_o)))
        else $error("outputs changed while advance_i was low");

endmodule

bind mem_subsys_top mem_subsys_chk u_chk (
    .clk(clk), .rst(rst), .advance_i(advance_i), .flush_i(flush_i), .valid_i(valid_i),
    .ram_req(ram_req), .ram_ack(ram_ack), .m2_excp(m2_excp), .wb_valid_o(wb_valid_o),
    .wb_we_o(wb_we_o), .wb_rd_o(wb_rd_o), .wb_data_o(wb_data_o), .excp_o(excp_o)
);

// File: testbench/mem_subsys_tb.sv
`timescale 1ns/1ps
`include "mem_defs.svh"

module mem_subsys_tb;

    localparam int RESET_CYCLES = 8;
    localparam int N_RAND = 16;
    localparam int TEST_CYCLES = RESET_CYCLES + 8 * N_RAND + 80;

    logic                   clk;
    logic                   rst;
    logic                   valid_i;
    mem_pkg::mem_op_e       op_i;
    logic [31:0]            vaddr_i;
    logic [31:0]            wdata_i;
    logic [4:0]             rd_i;
    logic                   trans_en_i;
    logic [1:0]             plv_i;
    logic                   advance_i;
    logic                   flush_i;
    logic                   tlb_we_i;
    logic [19:0]            tlb_vpn_i;
    logic [19:0]            tlb_ppn_i;
    logic                   tlb_v_i;
    logic                   tlb_d_i;
    logic [1:0]             tlb_plv_i;
    logic                   wb_valid_o;
    logic                   wb_we_o;
    logic [4:0]             wb_rd_o;
    logic [31:0]            wb_data_o;
    mem_pkg::excp_e         excp_o;

    logic [31:0] mem_model [`MEM_RAM_WORDS];
    logic        model_llbit;
    // Destination register of the most recent op
    logic [4:0]  last_rd;
    int          errors;
    int          checks;
    int          tests;
    int          err_mark;

    mem_subsys_top DUT (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        #(TEST_CYCLES * 40 + 2000);
        $display("Watchdog expired before the tests completed");
        $display("=== FAIL ===");
        $finish;
    end

    // Expected load result from a memory word
    function automatic logic [31:0] load_value(mem_pkg::mem_op_e op, logic [31:0] word,
                                               logic [1:0] ofs);
        logic [7:0]  b;
        logic [15:0] h;
        b = 8'(word >> (8 * ofs));
        h = 16'(word >> (8 * ofs));
        case (op)
            mem_pkg::MEM_LD_B:  return {{24{b[7]}}, b};
            mem_pkg::MEM_LD_BU: return {24'b0, b};
            mem_pkg::MEM_LD_H:  return {{16{h[15]}}, h};
            mem_pkg::MEM_LD_HU: return {16'b0, h};
            default:            return word;
        endcase
    endfunction

    task automatic check_wb(input logic [4:0] rd, input logic exp_we, input logic [31:0] exp_data,
                            input mem_pkg::excp_e exp_excp);
        checks++;
        assert (wb_valid_o === 1'b1) else begin
            $display("ERR wb_valid_o got %h exp 1", wb_valid_o);
            errors++;
        end
        assert (wb_we_o === exp_we) else begin
            $display("ERR wb_we_o got %h exp %h", wb_we_o, exp_we);
            errors++;
        end
        assert (excp_o === exp_excp) else begin
            $display("ERR excp_o got %h exp %h", excp_o, exp_excp);
            errors++;
        end
        if (exp_we) begin
            assert (wb_rd_o === rd) else begin
                $display("ERR wb_rd_o got %h exp %h", wb_rd_o, rd);
                errors++;
            end
            assert (wb_data_o === exp_data) else begin
                $display("ERR wb_data_o got %h exp %h", wb_data_o, exp_data);
                errors++;
            end
        end
    endtask

    // One op per cycle, entered and left 2 ns after a rising edge
    task automatic run_op(input mem_pkg::mem_op_e op, input logic [31:0] va,
                          input logic [31:0] wd, input logic exp_we,
                          input logic [31:0] exp_data, input mem_pkg::excp_e exp_excp);
        logic [4:0] rd;
        rd = 5'($urandom_range(31, 1));
        last_rd = rd;
        valid_i = 1'b1;
        op_i = op;
        vaddr_i = va;
        wdata_i = wd;
        rd_i = rd;
        @(posedge clk);
        #2;
        valid_i = 1'b0;
        op_i = mem_pkg::MEM_NOP;
        check_wb(rd, exp_we, exp_data, exp_excp);
    endtask

    task automatic store(input mem_pkg::mem_op_e op, input logic [31:0] va,
                         input logic [31:0] pa, input logic [31:0] wd);
        case (op)
            mem_pkg::MEM_ST_B: mem_model[pa[9:2]][8*pa[1:0] +: 8] = wd[7:0];
            mem_pkg::MEM_ST_H: mem_model[pa[9:2]][8*pa[1:0] +: 16] = wd[15:0];
            default:           mem_model[pa[9:2]] = wd;
        endcase
        run_op(op, va, wd, 1'b0, '0, mem_pkg::EXCP_NONE);
    endtask

    task automatic load(input mem_pkg::mem_op_e op, input logic [31:0] va, input logic [31:0] pa);
        run_op(op, va, $urandom, 1'b1, load_value(op, mem_model[pa[9:2]], pa[1:0]),
               mem_pkg::EXCP_NONE);
    endtask

    task automatic tlb_fill(input logic [19:0] vpn, input logic [19:0] ppn, input logic v,
                            input logic d, input logic [1:0] plv);
        tlb_we_i = 1'b1;
        tlb_vpn_i = vpn;
        tlb_ppn_i = ppn;
        tlb_v_i = v;
        tlb_d_i = d;
        tlb_plv_i = plv;
        @(posedge clk);
        #2;
        tlb_we_i = 1'b0;
    endtask

    task automatic end_test(input string name);
        tests++;
        $display("test %s finished with %0d errors", name, errors - err_mark);
        err_mark = errors;
    endtask

    initial begin
        logic [31:0] a;
        logic [31:0] d;
        logic [1:0]  o;
        void'($urandom(75));
        rst = 1'b1;
        valid_i = 1'b0;
        op_i = mem_pkg::MEM_NOP;
        vaddr_i = '0;
        wdata_i = '0;
        rd_i = '0;
        trans_en_i = 1'b0;
        plv_i = 2'd0;
        advance_i = 1'b1;
        flush_i = 1'b0;
        tlb_we_i = 1'b0;
        tlb_vpn_i = '0;
        tlb_ppn_i = '0;
        tlb_v_i = 1'b0;
        tlb_d_i = 1'b0;
        tlb_plv_i = 2'd0;
        errors = 0;
        checks = 0;
        tests = 0;
        err_mark = 0;
        model_llbit = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        rst = 1'b0;

        // Idle after reset
        repeat (3) begin
            @(posedge clk);
            #2;
            checks++;
            assert (wb_valid_o === 1'b0 && excp_o === mem_pkg::EXCP_NONE) else begin
                $display("ERR wb_valid_o/excp_o got %h/%h exp 0/0", wb_valid_o, excp_o);
                errors++;
            end
        end
        end_test("reset");

        for (int i = 0; i < N_RAND; i++) begin
            a = {22'b0, 8'($urandom), 2'b00};
            store(mem_pkg::MEM_ST_W, a, a, $urandom);
            o = 2'($urandom);
            store(mem_pkg::MEM_ST_B, a | o, a | o, $urandom);
            o = {1'($urandom), 1'b0};
            store(mem_pkg::MEM_ST_H, a | o, a | o, $urandom);
            o = 2'($urandom);
            load(mem_pkg::MEM_LD_B, a | o, a | o);
            load(mem_pkg::MEM_LD_BU, a | o, a | o);
            o = {1'($urandom), 1'b0};
            load(mem_pkg::MEM_LD_H, a | o, a | o);
            load(mem_pkg::MEM_LD_HU, a | o, a | o);
            load(mem_pkg::MEM_LD_W, a, a);
        end
        end_test("random_widths");

        tlb_fill(20'h00010, 20'h00000, 1'b1, 1'b1, 2'd3);
        tlb_fill(20'h00021, 20'h00000, 1'b0, 1'b1, 2'd3);
        tlb_fill(20'h00032, 20'h00000, 1'b1, 1'b1, 2'd0);
        tlb_fill(20'h00043, 20'h00000, 1'b1, 1'b0, 2'd3);
        a = 32'h0000_0080;
        trans_en_i = 1'b1;
        store(mem_pkg::MEM_ST_W, 32'h0001_0000 | a, a, $urandom);
        store(mem_pkg::MEM_ST_B, 32'h0001_0003 | a, a | 3, $urandom);
        load(mem_pkg::MEM_LD_W, 32'h0001_0000 | a, a);
        trans_en_i = 1'b0;
        load(mem_pkg::MEM_LD_W, a, a);
        end_test("translation");

        a = 32'h0000_0100;
        store(mem_pkg::MEM_ST_W, a, a, $urandom);
        trans_en_i = 1'b1;
        run_op(mem_pkg::MEM_LD_W, 32'h0005_0100, 0, 1'b0, 0, mem_pkg::EXCP_TLBR);
        run_op(mem_pkg::MEM_LD_W, 32'h0002_1100, 0, 1'b0, 0, mem_pkg::EXCP_PIL);
        run_op(mem_pkg::MEM_ST_W, 32'h0002_1100, $urandom, 1'b0, 0, mem_pkg::EXCP_PIS);
        run_op(mem_pkg::MEM_ST_W, 32'h0004_3100, $urandom, 1'b0, 0, mem_pkg::EXCP_PME);
        plv_i = 2'd3;
        run_op(mem_pkg::MEM_LD_W, 32'h0003_2100, 0, 1'b0, 0, mem_pkg::EXCP_PPI);
        run_op(mem_pkg::MEM_ST_W, 32'h8001_0100, $urandom, 1'b0, 0, mem_pkg::EXCP_ADEM);
        plv_i = 2'd0;
        trans_en_i = 1'b0;
        load(mem_pkg::MEM_LD_W, a, a);
        end_test("exceptions");

        a = 32'h0000_0200;
        store(mem_pkg::MEM_ST_W, a, a, $urandom);
        load(mem_pkg::MEM_LL, a, a);
        model_llbit = 1'b1;
        d = $urandom;
        mem_model[a[9:2]] = model_llbit ? d : mem_model[a[9:2]];
        run_op(mem_pkg::MEM_SC, a, d, 1'b1, {31'b0, model_llbit}, mem_pkg::EXCP_NONE);
        model_llbit = 1'b0;
        run_op(mem_pkg::MEM_SC, a, $urandom, 1'b1, {31'b0, model_llbit}, mem_pkg::EXCP_NONE);
        load(mem_pkg::MEM_LD_W, a, a);
        end_test("ll_sc");

        // A load stalls while a store waits at the input
        a = 32'h0000_0300;
        store(mem_pkg::MEM_ST_W, a, a, $urandom);
        load(mem_pkg::MEM_LD_W, a, a);
        advance_i = 1'b0;
        valid_i = 1'b1;
        op_i = mem_pkg::MEM_ST_W;
        vaddr_i = a;
        wdata_i = ~mem_model[a[9:2]];
        repeat (4) begin
            @(posedge clk);
            #2;
            check_wb(last_rd, 1'b1, mem_model[a[9:2]], mem_pkg::EXCP_NONE);
        end
        advance_i = 1'b1;
        valid_i = 1'b0;
        op_i = mem_pkg::MEM_NOP;
        @(posedge clk);
        #2;
        flush_i = 1'b1;
        valid_i = 1'b1;
        op_i = mem_pkg::MEM_ST_W;
        @(posedge clk);
        #2;
        flush_i = 1'b0;
        valid_i = 1'b0;
        op_i = mem_pkg::MEM_NOP;
        checks++;
        assert (wb_valid_o === 1'b0) else begin
            $display("ERR wb_valid_o got %h exp 0", wb_valid_o);
            errors++;
        end
        load(mem_pkg::MEM_LD_W, a, a);
        end_test("stall_flush");

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// File: all.f
+incdir+design
design/mem_pkg.sv
design/dtlb.sv
design/mem1_stage.sv
design/dcache_ram.sv
design/mem2_stage.sv
design/mem_subsys_top.sv
testbench/mem_subsys_chk.sv
testbench/mem_subsys_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= mem_subsys_tb
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := $(filter-out +%,$(shell cat all.f)) design/mem_defs.svh
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): all.f $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f all.f

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "=== PASS ==="

clean:
	rm -rf $(BUILD_DIR)
